/* include/axi_ic_settings.svh */
`ifndef AXI_IC_SETTINGS_SVH
`define AXI_IC_SETTINGS_SVH

// Bus widths shared by every port of the read interconnect
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_ID_WIDTH   4
`define AXI_LEN_WIDTH  8
`define AXI_SIZE_WIDTH 3

// Systolic array control registers
`define SA_BASE_ADDR     32'hF000_0000
`define SA_LAST_ADDR     32'hF000_0014

// CORDIC control registers
`define CORDIC_BASE_ADDR 32'hF000_0018
`define CORDIC_LAST_ADDR 32'hF000_0024

// Both window bounds are inclusive
// Any address outside the two windows belongs to DRAM

`endif

/* source/axi_map_pkg.sv */
package axi_map_pkg;

    // Destination of the open CPU read
    // TGT_NONE means the CPU port may accept a new read
    typedef enum logic [1:0] {
        TGT_NONE   = 2'b00,
        TGT_SA     = 2'b01,
        TGT_CORDIC = 2'b10,
        TGT_DRAM   = 2'b11
    } read_target_e;

    // Master that holds the DRAM read address and data channels
    typedef enum logic {
        OWN_S0 = 1'b0,
        OWN_S1 = 1'b1
    } dram_owner_e;

endpackage

/* source/axi_chan_pkg.sv */
package axi_chan_pkg;

    // RRESP codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // ARBURST codes with 2'b11 reserved
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

endpackage

/* source/read_request_router.sv */
`timescale 1ns/100ps
`include "axi_ic_settings.svh"

module read_request_router import axi_map_pkg::*; (
    input  logic                       ACLK,
    input  logic                       ARESETN,
    input  logic [`AXI_ADDR_WIDTH-1:0] s0_araddr,
    input  logic                       s0_arvalid,
    output logic                       s0_arready,
    output logic [`AXI_ADDR_WIDTH-1:0] m0_araddr,
    output logic                       m0_arvalid,
    input  logic                       m0_arready,
    output logic [`AXI_ADDR_WIDTH-1:0] m1_araddr,
    output logic                       m1_arvalid,
    input  logic                       m1_arready,
    output logic                       s0_dram_req,
    input  logic                       s0_dram_arready,
    input  logic                       s0_read_done,
    output read_target_e               s0_target
);

    read_target_e addr_target;
    logic         cpu_idle;

    // Memory map decode of the CPU read address
    always_comb begin
        if (s0_araddr >= `SA_BASE_ADDR && s0_araddr <= `SA_LAST_ADDR) begin
            addr_target = TGT_SA;
        end else if (s0_araddr >= `CORDIC_BASE_ADDR && s0_araddr <= `CORDIC_LAST_ADDR) begin
            addr_target = TGT_CORDIC;
        end else begin
            addr_target = TGT_DRAM;
        end
    end

    // New CPU reads wait until the open one has finished
    assign cpu_idle = (s0_target == TGT_NONE);

    assign m0_araddr   = s0_araddr;
    assign m1_araddr   = s0_araddr;
    assign m0_arvalid  = s0_arvalid && cpu_idle && (addr_target == TGT_CORDIC);
    assign m1_arvalid  = s0_arvalid && cpu_idle && (addr_target == TGT_SA);
    assign s0_dram_req = s0_arvalid && cpu_idle && (addr_target == TGT_DRAM);

    // Ready comes back from whichever port the address selects
    always_comb begin
        s0_arready = 1'b0;
        if (cpu_idle) begin
            case (addr_target)
                TGT_CORDIC: s0_arready = m0_arready;
                TGT_SA:     s0_arready = m1_arready;
                TGT_DRAM:   s0_arready = s0_dram_arready;
                default:    s0_arready = 1'b0;
            endcase
        end
    end

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            s0_target <= TGT_NONE;
        end else if (s0_arvalid && s0_arready) begin
            s0_target <= addr_target;
        end else if (s0_read_done) begin
            s0_target <= TGT_NONE;
        end
    end

endmodule

/* source/dram_read_arbiter.sv */
`timescale 1ns/100ps
`include "axi_ic_settings.svh"

module dram_read_arbiter import axi_map_pkg::*, axi_chan_pkg::*; (
    input  logic                       ACLK,
    input  logic                       ARESETN,
    input  logic                       s0_dram_req,
    output logic                       s0_dram_arready,
    input  logic [`AXI_ID_WIDTH-1:0]   s0_arid,
    input  logic [`AXI_ADDR_WIDTH-1:0] s0_araddr,
    input  logic [`AXI_LEN_WIDTH-1:0]  s0_arlen,
    input  logic [`AXI_SIZE_WIDTH-1:0] s0_arsize,
    input  axi_burst_e                 s0_arburst,
    input  logic [`AXI_ID_WIDTH-1:0]   s1_arid,
    input  logic [`AXI_ADDR_WIDTH-1:0] s1_araddr,
    input  logic [`AXI_LEN_WIDTH-1:0]  s1_arlen,
    input  logic [`AXI_SIZE_WIDTH-1:0] s1_arsize,
    input  axi_burst_e                 s1_arburst,
    input  logic                       s1_arvalid,
    output logic                       s1_arready,
    output logic [`AXI_ID_WIDTH-1:0]   m2_arid,
    output logic [`AXI_ADDR_WIDTH-1:0] m2_araddr,
    output logic [`AXI_LEN_WIDTH-1:0]  m2_arlen,
    output logic [`AXI_SIZE_WIDTH-1:0] m2_arsize,
    output axi_burst_e                 m2_arburst,
    output logic                       m2_arvalid,
    input  logic                       m2_arready,
    input  logic                       s0_read_done,
    input  logic                       s1_read_done,
    output dram_owner_e                dram_owner,
    output logic                       dram_busy
);

    // IDLE picks an owner, ADDR presents its AR, BURST waits for the last beat
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'b00,
        ARB_ADDR  = 2'b01,
        ARB_BURST = 2'b10
    } arb_state_e;

    arb_state_e state;
    logic       owner_req;
    logic       owner_done;
    logic       ar_grant;

    assign owner_req  = (dram_owner == OWN_S0) ? s0_dram_req : s1_arvalid;
    assign owner_done = (dram_owner == OWN_S0) ? s0_read_done : s1_read_done;
    assign ar_grant   = (state == ARB_ADDR);
    assign dram_busy  = (state == ARB_BURST);

    // The owner is frozen in ADDR so the m2 fields stay stable until accepted
    assign m2_arvalid      = ar_grant && owner_req;
    assign s0_dram_arready = ar_grant && (dram_owner == OWN_S0) && m2_arready;
    assign s1_arready      = ar_grant && (dram_owner == OWN_S1) && m2_arready;

    always_comb begin
        if (dram_owner == OWN_S0) begin
            m2_arid    = s0_arid;
            m2_araddr  = s0_araddr;
            m2_arlen   = s0_arlen;
            m2_arsize  = s0_arsize;
            m2_arburst = s0_arburst;
        end else begin
            m2_arid    = s1_arid;
            m2_araddr  = s1_araddr;
            m2_arlen   = s1_arlen;
            m2_arsize  = s1_arsize;
            m2_arburst = s1_arburst;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            state      <= ARB_IDLE;
            dram_owner <= OWN_S0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (s0_dram_req && s1_arvalid) begin
                        // With both waiting the master that did not own it last goes next
                        dram_owner <= (dram_owner == OWN_S0) ? OWN_S1 : OWN_S0;
                        state      <= ARB_ADDR;
                    end else if (s0_dram_req) begin
                        dram_owner <= OWN_S0;
                        state      <= ARB_ADDR;
                    end else if (s1_arvalid) begin
                        dram_owner <= OWN_S1;
                        state      <= ARB_ADDR;
                    end
                end
                ARB_ADDR: begin
                    if (m2_arvalid && m2_arready) begin
                        state <= ARB_BURST;
                    end else if (!owner_req) begin
                        state <= ARB_IDLE;
                    end
                end
                ARB_BURST: begin
                    if (owner_done) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

/* source/read_return_mux.sv */
`timescale 1ns/100ps
`include "axi_ic_settings.svh"

module read_return_mux import axi_map_pkg::*, axi_chan_pkg::*; (
    input  logic                       ACLK,
    input  logic                       ARESETN,
    input  logic [`AXI_ID_WIDTH-1:0]   s0_arid,
    input  logic                       s0_ar_accept,
    input  read_target_e               s0_target,
    input  dram_owner_e                dram_owner,
    input  logic                       dram_busy,
    input  logic [`AXI_DATA_WIDTH-1:0] m0_rdata,
    input  axi_resp_e                  m0_rresp,
    input  logic                       m0_rvalid,
    output logic                       m0_rready,
    input  logic [`AXI_DATA_WIDTH-1:0] m1_rdata,
    input  axi_resp_e                  m1_rresp,
    input  logic                       m1_rvalid,
    output logic                       m1_rready,
    input  logic [`AXI_ID_WIDTH-1:0]   m2_rid,
    input  logic [`AXI_DATA_WIDTH-1:0] m2_rdata,
    input  axi_resp_e                  m2_rresp,
    input  logic                       m2_rlast,
    input  logic                       m2_rvalid,
    output logic                       m2_rready,
    output logic [`AXI_ID_WIDTH-1:0]   s0_rid,
    output logic [`AXI_DATA_WIDTH-1:0] s0_rdata,
    output axi_resp_e                  s0_rresp,
    output logic                       s0_rlast,
    output logic                       s0_rvalid,
    input  logic                       s0_rready,
    output logic [`AXI_ID_WIDTH-1:0]   s1_rid,
    output logic [`AXI_DATA_WIDTH-1:0] s1_rdata,
    output axi_resp_e                  s1_rresp,
    output logic                       s1_rlast,
    output logic                       s1_rvalid,
    input  logic                       s1_rready,
    output logic                       s0_read_done,
    output logic                       s1_read_done
);

    logic [`AXI_ID_WIDTH-1:0] s0_arid_held;
    logic                     s0_owns_dram;
    logic                     s1_owns_dram;

    // AXI4-Lite targets carry no ID, so the CPU ID is kept for the reply
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            s0_arid_held <= '0;
        end else if (s0_ar_accept) begin
            s0_arid_held <= s0_arid;
        end
    end

    assign s0_owns_dram = dram_busy && (dram_owner == OWN_S0) && (s0_target == TGT_DRAM);
    assign s1_owns_dram = dram_busy && (dram_owner == OWN_S1);

    always_comb begin
        s0_rid    = s0_arid_held;
        s0_rdata  = '0;
        s0_rresp  = OKAY;
        s0_rlast  = 1'b0;
        s0_rvalid = 1'b0;
        m0_rready = 1'b0;
        m1_rready = 1'b0;
        case (s0_target)
            TGT_CORDIC: begin
                s0_rdata  = m0_rdata;
                s0_rresp  = m0_rresp;
                s0_rlast  = 1'b1;
                s0_rvalid = m0_rvalid;
                m0_rready = s0_rready;
            end
            TGT_SA: begin
                s0_rdata  = m1_rdata;
                s0_rresp  = m1_rresp;
                s0_rlast  = 1'b1;
                s0_rvalid = m1_rvalid;
                m1_rready = s0_rready;
            end
            TGT_DRAM: begin
                if (s0_owns_dram) begin
                    s0_rid    = m2_rid;
                    s0_rdata  = m2_rdata;
                    s0_rresp  = m2_rresp;
                    s0_rlast  = m2_rlast;
                    s0_rvalid = m2_rvalid;
                end
            end
            default: s0_rvalid = 1'b0;
        endcase
    end

    // Accelerator only ever reads from DRAM
    always_comb begin
        s1_rid    = '0;
        s1_rdata  = '0;
        s1_rresp  = OKAY;
        s1_rlast  = 1'b0;
        s1_rvalid = 1'b0;
        if (s1_owns_dram) begin
            s1_rid    = m2_rid;
            s1_rdata  = m2_rdata;
            s1_rresp  = m2_rresp;
            s1_rlast  = m2_rlast;
            s1_rvalid = m2_rvalid;
        end
    end

    assign m2_rready = (s0_owns_dram && s0_rready) || (s1_owns_dram && s1_rready);

    // One-cycle pulse on the accepted last beat
    assign s0_read_done = s0_rvalid && s0_rready && s0_rlast;
    assign s1_read_done = s1_rvalid && s1_rready && s1_rlast;

endmodule

/* source/axi_read_interconnect.sv */
`timescale 1ns/100ps
`include "axi_ic_settings.svh"

module axi_read_interconnect import axi_map_pkg::*, axi_chan_pkg::*; (
    input  logic                       ACLK,
    input  logic                       ARESETN,
    // CPU master
    input  logic [`AXI_ID_WIDTH-1:0]   s0_arid,
    input  logic [`AXI_ADDR_WIDTH-1:0] s0_araddr,
    input  logic [`AXI_LEN_WIDTH-1:0]  s0_arlen,
    input  logic [`AXI_SIZE_WIDTH-1:0] s0_arsize,
    input  axi_burst_e                 s0_arburst,
    input  logic                       s0_arvalid,
    output logic                       s0_arready,
    output logic [`AXI_ID_WIDTH-1:0]   s0_rid,
    output logic [`AXI_DATA_WIDTH-1:0] s0_rdata,
    output axi_resp_e                  s0_rresp,
    output logic                       s0_rlast,
    output logic                       s0_rvalid,
    input  logic                       s0_rready,
    // Accelerator master
    input  logic [`AXI_ID_WIDTH-1:0]   s1_arid,
    input  logic [`AXI_ADDR_WIDTH-1:0] s1_araddr,
    input  logic [`AXI_LEN_WIDTH-1:0]  s1_arlen,
    input  logic [`AXI_SIZE_WIDTH-1:0] s1_arsize,
    input  axi_burst_e                 s1_arburst,
    input  logic                       s1_arvalid,
    output logic                       s1_arready,
    output logic [`AXI_ID_WIDTH-1:0]   s1_rid,
    output logic [`AXI_DATA_WIDTH-1:0] s1_rdata,
    output axi_resp_e                  s1_rresp,
    output logic                       s1_rlast,
    output logic                       s1_rvalid,
    input  logic                       s1_rready,
    // CORDIC registers on AXI4-Lite
    output logic [`AXI_ADDR_WIDTH-1:0] m0_araddr,
    output logic                       m0_arvalid,
    input  logic                       m0_arready,
    input  logic [`AXI_DATA_WIDTH-1:0] m0_rdata,
    input  axi_resp_e                  m0_rresp,
    input  logic                       m0_rvalid,
    output logic                       m0_rready,
    // Systolic array registers on AXI4-Lite
    output logic [`AXI_ADDR_WIDTH-1:0] m1_araddr,
    output logic                       m1_arvalid,
    input  logic                       m1_arready,
    input  logic [`AXI_DATA_WIDTH-1:0] m1_rdata,
    input  axi_resp_e                  m1_rresp,
    input  logic                       m1_rvalid,
    output logic                       m1_rready,
    // DRAM controller on AXI4
    output logic [`AXI_ID_WIDTH-1:0]   m2_arid,
    output logic [`AXI_ADDR_WIDTH-1:0] m2_araddr,
    output logic [`AXI_LEN_WIDTH-1:0]  m2_arlen,
    output logic [`AXI_SIZE_WIDTH-1:0] m2_arsize,
    output axi_burst_e                 m2_arburst,
    output logic                       m2_arvalid,
    input  logic                       m2_arready,
    input  logic [`AXI_ID_WIDTH-1:0]   m2_rid,
    input  logic [`AXI_DATA_WIDTH-1:0] m2_rdata,
    input  axi_resp_e                  m2_rresp,
    input  logic                       m2_rlast,
    input  logic                       m2_rvalid,
    output logic                       m2_rready
);

    logic         s0_dram_req;
    logic         s0_dram_arready;
    read_target_e s0_target;
    dram_owner_e  dram_owner;
    logic         dram_busy;
    logic         s0_read_done;
    logic         s1_read_done;
    logic         s0_ar_accept;

    // CPU AR handshake captures the ID for register reads
    assign s0_ar_accept = s0_arvalid && s0_arready;

    // Address decode and AXI4-Lite forwarding
    read_request_router u_read_request_router (.*);

    // DRAM AR ownership
    dram_read_arbiter u_dram_read_arbiter (.*);

    // R channel steering back to the masters
    read_return_mux u_read_return_mux (.*);

endmodule

/* tests/axi_read_assertions.sv */
`timescale 1ns/100ps
`include "axi_ic_settings.svh"

module axi_read_assertions import axi_map_pkg::*, axi_chan_pkg::*; (
    input logic                       ACLK,
    input logic                       ARESETN,
    input logic                       m0_arvalid,
    input logic                       m1_arvalid,
    input logic                       s0_dram_req,
    input logic [`AXI_ID_WIDTH-1:0]   m2_arid,
    input logic [`AXI_ADDR_WIDTH-1:0] m2_araddr,
    input logic [`AXI_LEN_WIDTH-1:0]  m2_arlen,
    input logic [`AXI_SIZE_WIDTH-1:0] m2_arsize,
    input axi_burst_e                 m2_arburst,
    input logic                       m2_arvalid,
    input logic                       m2_arready,
    input dram_owner_e                dram_owner,
    input logic                       dram_busy
);

    // No read address may be offered to a target while reset is held
    no_arvalid_in_reset: assert property (@(posedge ACLK)
        !ARESETN |-> !(m0_arvalid || m1_arvalid || m2_arvalid))
        else $error("arvalid output high during reset");

    // A waiting DRAM request keeps its address fields
    m2_ar_stable: assert property (@(posedge ACLK) disable iff (!ARESETN)
        (m2_arvalid && !m2_arready) |=>
            $stable({m2_arid, m2_araddr, m2_arlen, m2_arsize, m2_arburst}))
        else $error("m2 address fields changed while waiting for arready");

    // The CPU request goes to one place only
    cpu_request_onehot: assert property (@(posedge ACLK) disable iff (!ARESETN)
        $onehot0({m0_arvalid, m1_arvalid, s0_dram_req}))
        else $error("CPU read routed to more than one target");

    owner_held_in_burst: assert property (@(posedge ACLK) disable iff (!ARESETN)
        dram_busy |=> $stable(dram_owner))
        else $error("DRAM owner changed during a burst");

endmodule

bind axi_read_interconnect axi_read_assertions u_axi_read_assertions (.*);

/* tests/tb_axi_read_interconnect.sv */
`timescale 1ns/100ps
`include "axi_ic_settings.svh"

module tb_axi_read_interconnect import axi_chan_pkg::*; ;

    localparam integer NUM_ROWS = 11;
    localparam integer TIMEOUT  = 200;
    localparam logic [31:0] TAG_CORDIC = 32'hC0D1_C000;
    localparam logic [31:0] TAG_SA     = 32'h5A5A_0000;
    localparam logic [31:0] TAG_DRAM   = 32'hD2A3_0000;
    localparam logic [`AXI_SIZE_WIDTH-1:0] CPU_SIZE   = 3'd2;
    localparam logic [`AXI_SIZE_WIDTH-1:0] ACCEL_SIZE = 3'd1;

    logic ACLK;
    logic ARESETN;
    logic [`AXI_ID_WIDTH-1:0]   s0_arid, s1_arid, s0_rid, s1_rid, m2_arid, m2_rid;
    logic [`AXI_ADDR_WIDTH-1:0] s0_araddr, s1_araddr, m0_araddr, m1_araddr, m2_araddr;
    logic [`AXI_LEN_WIDTH-1:0]  s0_arlen, s1_arlen, m2_arlen;
    logic [`AXI_SIZE_WIDTH-1:0] s0_arsize, s1_arsize, m2_arsize;
    axi_burst_e                 s0_arburst, s1_arburst, m2_arburst;
    logic [`AXI_DATA_WIDTH-1:0] s0_rdata, s1_rdata, m0_rdata, m1_rdata, m2_rdata;
    axi_resp_e                  s0_rresp, s1_rresp, m0_rresp, m1_rresp, m2_rresp;
    logic s0_arvalid, s0_arready, s0_rlast, s0_rvalid, s0_rready;
    logic s1_arvalid, s1_arready, s1_rlast, s1_rvalid, s1_rready;
    logic m0_arvalid, m0_arready, m0_rvalid, m0_rready;
    logic m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    logic m2_arvalid, m2_arready, m2_rlast, m2_rvalid, m2_rready;

    integer seed;
    integer error_count;
    integer check_count;
    integer row;

    // Port 2 in the stimulus table issues DRAM reads from both masters at once
    string       row_name [NUM_ROWS];
    integer      row_port [NUM_ROWS];
    logic [31:0] row_addr [NUM_ROWS];
    logic [7:0]  row_len  [NUM_ROWS];
    logic [3:0]  row_id   [NUM_ROWS];

    axi_read_interconnect u_axi_read_interconnect (.*);

    initial begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    function automatic logic random_bit();
        integer r;
        r = $random(seed);
        return r[0];
    endfunction

    // Data tag of the target that a read from this port and address must reach
    function automatic logic [31:0] expected_tag(input integer port, input logic [31:0] addr);
        if (port != 0) begin
            return TAG_DRAM;
        end else if (addr >= `SA_BASE_ADDR && addr <= `SA_LAST_ADDR) begin
            return TAG_SA;
        end else if (addr >= `CORDIC_BASE_ADDR && addr <= `CORDIC_LAST_ADDR) begin
            return TAG_CORDIC;
        end
        return TAG_DRAM;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped: %s", why);
        $display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic add_row(input integer idx, input string name, input integer port,
                           input logic [31:0] addr, input logic [7:0] len, input logic [3:0] id);
        row_name[idx] = name;
        row_port[idx] = port;
        row_addr[idx] = addr;
        row_len[idx]  = len;
        row_id[idx]   = id;
    endtask

    task automatic drive_ar(input integer port, input logic valid, input logic [31:0] addr,
                            input logic [7:0] len, input logic [3:0] id);
        if (port == 0) begin
            s0_arvalid <= valid;
            s0_araddr  <= addr;
            s0_arlen   <= len;
            s0_arid    <= id;
        end else begin
            s1_arvalid <= valid;
            s1_araddr  <= addr;
            s1_arlen   <= len;
            s1_arid    <= id;
        end
    endtask

    task automatic drive_rready(input integer port, input logic ready);
        if (port == 0) begin
            s0_rready <= ready;
        end else begin
            s1_rready <= ready;
        end
    endtask

    // One complete read from a master with every beat checked against the target models
    task automatic run_read(input string name, input integer port, input logic [31:0] addr,
                            input logic [7:0] len, input logic [3:0] id);
        integer                     waited;
        integer                     beat;
        integer                     beats;
        logic [31:0]                tag;
        logic [`AXI_SIZE_WIDTH-1:0] size;
        logic                       rvalid;
        logic                       rready;
        logic                       rlast;
        logic [31:0]                rdata;
        logic [3:0]                 rid;
        logic [1:0]                 rresp;
        tag   = expected_tag(port, addr);
        size  = (port == 0) ? CPU_SIZE : ACCEL_SIZE;
        beats = (tag == TAG_DRAM) ? int'(len) + 1 : 1;
        @(posedge ACLK);
        drive_ar(port, 1'b1, addr, len, id);
        waited = 0;
        @(posedge ACLK);
        while (!(port == 0 ? s0_arready : s1_arready) && waited < TIMEOUT) begin
            waited = waited + 1;
            @(posedge ACLK);
        end
        if (!(port == 0 ? s0_arready : s1_arready)) begin
            abort_run({name, " read address was never accepted"});
        end
        // DRAM AR fields as seen in the handshake cycle
        if (tag == TAG_DRAM) begin
            check_value({name, " dram arsize"}, 32'(size), 32'(m2_arsize));
            check_value({name, " dram arburst"}, 32'(INCR), 32'(m2_arburst));
        end
        drive_ar(port, 1'b0, addr, len, id);
        beat   = 0;
        waited = 0;
        while (beat < beats && waited < TIMEOUT) begin
            drive_rready(port, random_bit());
            @(posedge ACLK);
            waited = waited + 1;
            if (port == 0) begin
                {rvalid, rready, rlast} = {s0_rvalid, s0_rready, s0_rlast};
                rdata = s0_rdata;
                rid   = s0_rid;
                rresp = s0_rresp;
            end else begin
                {rvalid, rready, rlast} = {s1_rvalid, s1_rready, s1_rlast};
                rdata = s1_rdata;
                rid   = s1_rid;
                rresp = s1_rresp;
            end
            if (rvalid && rready) begin
                check_value($sformatf("%s beat %0d data", name, beat), (addr + beat) ^ tag, rdata);
                check_value($sformatf("%s beat %0d id", name, beat), 32'(id), 32'(rid));
                check_value($sformatf("%s beat %0d resp", name, beat), 32'(OKAY), 32'(rresp));
                check_value($sformatf("%s beat %0d last", name, beat),
                            32'(beat == beats - 1), 32'(rlast));
                beat = beat + 1;
            end
        end
        drive_rready(port, 1'b0);
        if (beat < beats) begin
            abort_run({name, " did not receive all of its read data"});
        end
    endtask

    // CORDIC register block returns one beat per read
    // RRESP reads SLVERR whenever no beat is offered
    initial begin : cordic_model
        integer waited;
        m0_arready <= 1'b0;
        m0_rvalid  <= 1'b0;
        m0_rdata   <= '0;
        m0_rresp   <= SLVERR;
        forever begin
            @(posedge ACLK);
            if (m0_arvalid && m0_arready) begin
                m0_arready <= 1'b0;
                m0_rvalid  <= 1'b1;
                m0_rdata   <= m0_araddr ^ TAG_CORDIC;
                m0_rresp   <= OKAY;
                waited = 0;
                @(posedge ACLK);
                while (!m0_rready && waited < TIMEOUT) begin
                    waited = waited + 1;
                    @(posedge ACLK);
                end
                if (!m0_rready) begin
                    abort_run("CORDIC read data was never accepted");
                end
                m0_rvalid <= 1'b0;
                m0_rresp  <= SLVERR;
            end else begin
                m0_arready <= m0_arvalid && random_bit();
            end
        end
    end

    // Systolic array register block
    initial begin : sa_model
        integer waited;
        m1_arready <= 1'b0;
        m1_rvalid  <= 1'b0;
        m1_rdata   <= '0;
        m1_rresp   <= SLVERR;
        forever begin
            @(posedge ACLK);
            if (m1_arvalid && m1_arready) begin
                m1_arready <= 1'b0;
                m1_rvalid  <= 1'b1;
                m1_rdata   <= m1_araddr ^ TAG_SA;
                m1_rresp   <= OKAY;
                waited = 0;
                @(posedge ACLK);
                while (!m1_rready && waited < TIMEOUT) begin
                    waited = waited + 1;
                    @(posedge ACLK);
                end
                if (!m1_rready) begin
                    abort_run("systolic array read data was never accepted");
                end
                m1_rvalid <= 1'b0;
                m1_rresp  <= SLVERR;
            end else begin
                m1_arready <= m1_arvalid && random_bit();
            end
        end
    end

    // DRAM controller with random gaps between beats
    initial begin : dram_model
        logic [31:0] addr;
        logic [7:0]  len;
        logic [3:0]  id;
        integer      beat;
        integer      waited;
        m2_arready <= 1'b0;
        m2_rvalid  <= 1'b0;
        m2_rlast   <= 1'b0;
        m2_rid     <= '0;
        m2_rdata   <= '0;
        m2_rresp   <= SLVERR;
        forever begin
            @(posedge ACLK);
            if (m2_arvalid && m2_arready) begin
                addr = m2_araddr;
                len  = m2_arlen;
                id   = m2_arid;
                m2_arready <= 1'b0;
                for (beat = 0; beat <= int'(len); beat = beat + 1) begin
                    if (random_bit()) begin
                        m2_rvalid <= 1'b0;
                        m2_rresp  <= SLVERR;
                        @(posedge ACLK);
                    end
                    m2_rvalid <= 1'b1;
                    m2_rid    <= id;
                    m2_rdata  <= (addr + beat) ^ TAG_DRAM;
                    m2_rresp  <= OKAY;
                    m2_rlast  <= (beat == int'(len));
                    waited = 0;
                    @(posedge ACLK);
                    while (!m2_rready && waited < TIMEOUT) begin
                        waited = waited + 1;
                        @(posedge ACLK);
                    end
                    if (!m2_rready) begin
                        abort_run("DRAM read beat was never accepted");
                    end
                end
                m2_rvalid <= 1'b0;
                m2_rlast  <= 1'b0;
                m2_rresp  <= SLVERR;
            end else begin
                m2_arready <= m2_arvalid && random_bit();
            end
        end
    end

    initial begin
        seed        = 77628;
        error_count = 0;
        check_count = 0;
        ARESETN    <= 1'b0;
        drive_ar(0, 1'b0, '0, '0, '0);
        drive_ar(1, 1'b0, '0, '0, '0);
        s0_arsize  <= CPU_SIZE;
        s1_arsize  <= ACCEL_SIZE;
        s0_arburst <= INCR;
        s1_arburst <= INCR;
        s0_rready  <= 1'b0;
        s1_rready  <= 1'b0;

        add_row(0, "sa_base", 0, `SA_BASE_ADDR, 8'd0, 4'd1);
        add_row(1, "sa_last", 0, `SA_LAST_ADDR, 8'd0, 4'd2);
        add_row(2, "cordic_base", 0, `CORDIC_BASE_ADDR, 8'd0, 4'd3);
        add_row(3, "cordic_last", 0, `CORDIC_LAST_ADDR, 8'd0, 4'd4);
        add_row(4, "cpu_dram_burst", 0, 32'h0000_1000, 8'd3, 4'd5);
        add_row(5, "cpu_below_sa", 0, 32'hEFFF_FFFC, 8'd0, 4'd6);
        add_row(6, "cpu_above_cordic", 0, 32'hF000_0028, 8'd1, 4'd7);
        add_row(7, "accel_burst", 1, 32'h2000_0000, 8'd7, 4'd8);
        add_row(8, "accel_reg_address", 1, 32'hF000_0018, 8'd2, 4'd9);
        add_row(9, "both_dram", 2, 32'h3000_0000, 8'd4, 4'd10);
        add_row(10, "both_dram_again", 2, 32'h4000_0040, 8'd2, 4'd12);

        repeat (4) @(posedge ACLK);
        ARESETN <= 1'b1;

        for (row = 0; row < NUM_ROWS; row = row + 1) begin
            if (row_port[row] == 2) begin
                // Same start cycle so the arbiter sees both requests together
                fork
                    run_read({row_name[row], "_cpu"}, 0, row_addr[row], row_len[row], row_id[row]);
                    run_read({row_name[row], "_accel"}, 1, row_addr[row] + 32'h100,
                             row_len[row] + 8'd1, row_id[row] + 4'd1);
                join
            end else begin
                run_read(row_name[row], row_port[row], row_addr[row], row_len[row], row_id[row]);
            end
        end

        repeat (4) @(posedge ACLK);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
source/axi_map_pkg.sv
source/axi_chan_pkg.sv
source/read_request_router.sv
source/dram_read_arbiter.sv
source/read_return_mux.sv
source/axi_read_interconnect.sv
tests/axi_read_assertions.sv
tests/tb_axi_read_interconnect.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f \
    --top-module tb_axi_read_interconnect -o tb_axi_read_interconnect
./obj_dir/tb_axi_read_interconnect | tee sim.log

if grep -qx ">>> PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
